//--- Bender.yml
package:
  name: ex_stage

sources:
  - verilog/ex_pkg.sv
  - verilog/ex_operand_select.sv
  - verilog/ex_alu.sv
  - verilog/ex_branch_unit.sv
  - verilog/ex_mult_stage.sv
  - verilog/ex_multiplier.sv
  - verilog/ex_complete_queue.sv
  - verilog/ex_stage.sv
  - target: simulation
    files:
      - verification/ex_stage_props.sv
      - verification/ex_stage_tb.sv

//--- verification/ex_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_props (
	input logic                                        clock,
	input logic                                        reset,
	input logic                                        complete_valid,
	input logic                                        reg_wr_en,
	input logic [$clog2(ex_pkg::COMPLETE_DEPTH+1)-1:0] queue_count
);

	int fail_count = 0;

	// occupancy never passes the buffer size
	queue_bounded: assert property (@(posedge clock) disable iff (reset)
		queue_count <= ex_pkg::COMPLETE_DEPTH)
	else begin
		fail_count++;
		$error("completion queue count %0d above depth", queue_count);
	end

	// every completion writes since tag 0 never enters the queue
	write_matches_valid: assert property (@(posedge clock) disable iff (reset)
		reg_wr_en == complete_valid)
	else begin
		fail_count++;
		$error("reg_wr_en and complete_valid differ");
	end

	// first cycle out of reset is quiet
	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !complete_valid)
	else begin
		fail_count++;
		$error("complete_valid high in the cycle after reset");
	end

endmodule

`default_nettype wire

//--- verification/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

	localparam int NUM_TAGS = 1 << ex_pkg::TAG_BITS;
	// alu sweep, branches, multiplies, collision rounds, tag 0 mix
	localparam int N_ISSUE  = 10 * 4 * 6 + 8 * 4 + 8 + 4 * 24 + 8 * 2 * ex_pkg::NUM_STAGE + 16;
	localparam int TIMEOUT_CYCLES = (N_ISSUE + ex_pkg::NUM_STAGE + 20) * 2;

	logic               clock, reset;
	logic               issue_valid, issue_cond_branch, issue_uncond_branch;
	ex_pkg::exec_unit_e issue_unit;
	ex_pkg::alu_func_e  issue_alu_func;
	ex_pkg::mult_func_e issue_mult_func;
	ex_pkg::opa_sel_e   issue_opa_sel;
	ex_pkg::opb_sel_e   issue_opb_sel;
	ex_pkg::xlen_t      issue_inst, issue_pc, issue_npc, issue_rs1_value, issue_rs2_value;
	ex_pkg::tag_t       issue_dest_tag;
	logic               complete_valid, reg_wr_en, branch_valid, take_branch;
	ex_pkg::tag_t       complete_tag;
	ex_pkg::xlen_t      complete_result, branch_target;

	integer        seed = 32'he451;
	int            cycle = 0;
	int            issued = 0;
	int            outstanding = 0;
	int            checks = 0;
	int            errors = 0;
	int            last_tag = 0;
	bit            pending   [NUM_TAGS];   // scoreboard, indexed by tag
	ex_pkg::xlen_t exp_value [NUM_TAGS];
	string         test_name [NUM_TAGS];
	int            br_due_q[$];            // branch outcomes, due cycle
	logic          br_take_q[$];
	ex_pkg::xlen_t br_target_q[$];
	string         br_name_q[$];
	ex_pkg::xlen_t extremes [4] = '{32'h80000000, 32'h7fffffff, 32'hffffffff, 32'h00000001};

	ex_stage u_ex_stage (.*);

	bind ex_stage ex_stage_props u_ex_stage_props (
		.clock          (clock),
		.reset          (reset),
		.complete_valid (complete_valid),
		.reg_wr_en      (reg_wr_en),
		.queue_count    (u_complete_queue.count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic ex_pkg::xlen_t operand_a(input ex_pkg::opa_sel_e sel,
		input ex_pkg::xlen_t pc, npc, rs1);
		case (sel)
			ex_pkg::OPA_IS_RS1: return rs1;
			ex_pkg::OPA_IS_NPC: return npc;
			ex_pkg::OPA_IS_PC:  return pc;
			default:            return '0;
		endcase
	endfunction

	function automatic ex_pkg::xlen_t operand_b(input ex_pkg::opb_sel_e sel,
		input ex_pkg::xlen_t inst, rs2);
		logic [11:0] s12;
		logic [12:0] b13;
		logic [20:0] j21;
		s12 = {inst[31:25], inst[11:7]};
		b13 = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		j21 = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		case (sel)
			ex_pkg::OPB_IS_I_IMM: return ex_pkg::xlen_t'($signed(inst) >>> 20);
			ex_pkg::OPB_IS_S_IMM: return {{20{s12[11]}}, s12};
			ex_pkg::OPB_IS_B_IMM: return {{19{b13[12]}}, b13};
			ex_pkg::OPB_IS_U_IMM: return inst & 32'hfffff000;
			ex_pkg::OPB_IS_J_IMM: return {{11{j21[20]}}, j21};
			default:              return rs2;
		endcase
	endfunction

	function automatic ex_pkg::xlen_t expected_writeback(input ex_pkg::exec_unit_e unit,
		input ex_pkg::alu_func_e alu_func, input ex_pkg::mult_func_e mult_func,
		input ex_pkg::opa_sel_e opa_sel, input ex_pkg::opb_sel_e opb_sel,
		input ex_pkg::xlen_t inst, pc, npc, rs1, rs2);
		ex_pkg::xlen_t a, b;
		logic [63:0]   wa, wb, prod;
		longint        sa;
		a = operand_a(opa_sel, pc, npc, rs1);
		b = operand_b(opb_sel, inst, rs2);
		sa = $signed(a);
		if (unit == ex_pkg::EXEC_BRANCH)
			return npc; // link value
		if (unit == ex_pkg::EXEC_MULT) begin
			wa = (mult_func == ex_pkg::MULHU) ? {32'b0, rs1} : {{32{rs1[31]}}, rs1};
			wb = (mult_func == ex_pkg::MULHSU || mult_func == ex_pkg::MULHU)
				? {32'b0, rs2} : {{32{rs2[31]}}, rs2};
			prod = wa * wb;
			return (mult_func == ex_pkg::MUL) ? rs1 * rs2 : prod[63:32];
		end
		case (alu_func)
			ex_pkg::ALU_ADD:  return a + b;
			ex_pkg::ALU_SUB:  return a - b;
			ex_pkg::ALU_AND:  return a & b;
			ex_pkg::ALU_OR:   return a | b;
			ex_pkg::ALU_XOR:  return a ^ b;
			ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ex_pkg::ALU_SLL:  return a << b[4:0];
			ex_pkg::ALU_SRL:  return a >> b[4:0];
			default:          return ex_pkg::xlen_t'(sa >>> b[4:0]); // sra via 64 bits
		endcase
	endfunction

	// {take, target}
	function automatic logic [32:0] expected_branch(input ex_pkg::opa_sel_e opa_sel,
		input ex_pkg::opb_sel_e opb_sel, input ex_pkg::xlen_t inst, pc, npc, rs1, rs2,
		input logic cond, uncond);
		logic taken;
		case (inst[14:12])
			3'd0:    taken = (rs1 == rs2);
			3'd1:    taken = (rs1 != rs2);
			3'd4:    taken = ($signed(rs1) < $signed(rs2));
			3'd5:    taken = !($signed(rs1) < $signed(rs2));
			3'd6:    taken = (rs1 < rs2);
			3'd7:    taken = !(rs1 < rs2);
			default: taken = 1'b0;
		endcase
		taken = uncond || (cond && taken);
		return {taken, operand_a(opa_sel, pc, npc, rs1) + operand_b(opb_sel, inst, rs2)};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic issue_op(input ex_pkg::exec_unit_e unit, input ex_pkg::alu_func_e alu_func,
		input ex_pkg::mult_func_e mult_func, input ex_pkg::opa_sel_e opa_sel,
		input ex_pkg::opb_sel_e opb_sel, input ex_pkg::xlen_t inst, rs1, rs2,
		input logic cond, uncond, use_tag, input string name);
		ex_pkg::tag_t  tag;
		ex_pkg::xlen_t pc;
		logic [32:0]   br;
		@(posedge clock);
		#1;
		tag = '0;
		if (use_tag) begin
			do last_tag = (last_tag == NUM_TAGS - 1) ? 1 : last_tag + 1;
			while (pending[last_tag]);
			tag = ex_pkg::tag_t'(last_tag);
		end
		pc = $random(seed) & 32'hfffffffc;
		issue_valid         = 1'b1;
		issue_unit          = unit;
		issue_alu_func      = alu_func;
		issue_mult_func     = mult_func;
		issue_opa_sel       = opa_sel;
		issue_opb_sel       = opb_sel;
		issue_inst          = inst;
		issue_pc            = pc;
		issue_npc           = pc + 4;
		issue_rs1_value     = rs1;
		issue_rs2_value     = rs2;
		issue_dest_tag      = tag;
		issue_cond_branch   = cond;
		issue_uncond_branch = uncond;
		issued++;
		if (tag != '0) begin
			pending[tag]   = 1'b1;
			exp_value[tag] = expected_writeback(unit, alu_func, mult_func, opa_sel, opb_sel,
				inst, pc, pc + 4, rs1, rs2);
			test_name[tag] = name;
			outstanding++;
		end
		if (unit == ex_pkg::EXEC_BRANCH) begin
			br = expected_branch(opa_sel, opb_sel, inst, pc, pc + 4, rs1, rs2, cond, uncond);
			br_due_q.push_back(cycle + 1); // registered outputs, one edge later
			br_take_q.push_back(br[32]);
			br_target_q.push_back(br[31:0]);
			br_name_q.push_back(name);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
			issue_valid = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare process, outputs sampled at the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (cycle >= 1 && issued == 0) begin
			checks++;
			assert (!complete_valid && !branch_valid && !take_branch) else begin
				errors++;
				$display("outputs active after reset before any issue");
			end
		end
		if (!reset && complete_valid) begin
			checks++;
			assert (reg_wr_en) else begin
				errors++;
				$display("complete_valid high with reg_wr_en low, tag %0d", complete_tag);
			end
			assert (complete_tag != '0 && pending[complete_tag]) else begin
				errors++;
				$display("completion for tag %0d which is not outstanding", complete_tag);
			end
			if (pending[complete_tag]) begin
				assert (complete_result == exp_value[complete_tag]) else begin
					errors++;
					$display("ERR %s tag %0d expected %h actual %h", test_name[complete_tag],
						complete_tag, exp_value[complete_tag], complete_result);
				end
				pending[complete_tag] = 1'b0;
				outstanding--;
			end
		end
		if (!reset && br_due_q.size() != 0 && br_due_q[0] == cycle) begin
			checks++;
			assert (branch_valid && take_branch == br_take_q[0]
				&& branch_target == br_target_q[0]) else begin
				errors++;
				$display("ERR %s expected take %b target %h actual valid %b take %b target %h",
					br_name_q[0], br_take_q[0], br_target_q[0], branch_valid, take_branch,
					branch_target);
			end
			void'(br_due_q.pop_front());
			void'(br_take_q.pop_front());
			void'(br_target_q.pop_front());
			void'(br_name_q.pop_front());
		end else if (!reset) begin
			assert (!branch_valid && !take_branch) else begin
				errors++;
				$display("branch outputs active with no branch issued");
			end
		end
	end

	initial begin
		wait (cycle >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, %0d results never completed", cycle, outstanding);
		$display("checks %0d errors %0d issued %0d", checks, errors, issued);
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		ex_pkg::xlen_t inst, rs1, rs2;
		logic [31:0]   r;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_unit = ex_pkg::EXEC_ALU;
		issue_alu_func = ex_pkg::ALU_ADD;
		issue_mult_func = ex_pkg::MUL;
		issue_opa_sel = ex_pkg::OPA_IS_RS1;
		issue_opb_sel = ex_pkg::OPB_IS_RS2;
		issue_inst = '0;
		issue_pc = '0;
		issue_npc = '0;
		issue_rs1_value = '0;
		issue_rs2_value = '0;
		issue_dest_tag = '0;
		issue_cond_branch = 1'b0;
		issue_uncond_branch = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		idle(3); // quiet window for the reset check

		// every alu function against every operand source
		for (int f = 0; f < 10; f++)
			for (int a = 0; a < 4; a++)
				for (int b = 0; b < 6; b++)
					issue_op(ex_pkg::EXEC_ALU, ex_pkg::alu_func_e'(f), ex_pkg::MUL,
						ex_pkg::opa_sel_e'(a), ex_pkg::opb_sel_e'(b), $random(seed),
						$random(seed), $random(seed), 1'b0, 1'b0, 1'b1,
						$sformatf("alu func %0d opa %0d opb %0d", f, a, b));
		idle(2);

		for (int f3 = 0; f3 < 8; f3++)
			for (int k = 0; k < 4; k++) begin
				inst = $random(seed);
				inst[14:12] = f3[2:0];
				rs1 = $random(seed);
				rs2 = k[0] ? rs1 : $random(seed); // half of them equal
				issue_op(ex_pkg::EXEC_BRANCH, ex_pkg::ALU_ADD, ex_pkg::MUL, ex_pkg::OPA_IS_PC,
					ex_pkg::OPB_IS_B_IMM, inst, rs1, rs2, 1'b1, 1'b0, 1'b1,
					$sformatf("branch funct3 %0d", f3));
			end
		for (int k = 0; k < 8; k++)
			issue_op(ex_pkg::EXEC_BRANCH, ex_pkg::ALU_ADD, ex_pkg::MUL,
				k[0] ? ex_pkg::OPA_IS_PC : ex_pkg::OPA_IS_RS1,
				k[0] ? ex_pkg::OPB_IS_J_IMM : ex_pkg::OPB_IS_I_IMM,
				$random(seed), $random(seed), $random(seed), 1'b0, 1'b1, 1'b1, "jump");
		idle(2);

		// back to back multiplies, corner operands first
		for (int mf = 0; mf < 4; mf++)
			for (int k = 0; k < 24; k++)
				issue_op(ex_pkg::EXEC_MULT, ex_pkg::ALU_ADD, ex_pkg::mult_func_e'(mf),
					ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2, '0,
					(k < 16) ? extremes[k / 4] : $random(seed),
					(k < 16) ? extremes[k % 4] : $random(seed),
					1'b0, 1'b0, 1'b1, $sformatf("mult func %0d", mf));
		idle(2);

		// alu ops land in the same cycle as the multiplies ahead of them
		for (int round = 0; round < 8; round++) begin
			for (int i = 0; i < ex_pkg::NUM_STAGE; i++) begin
				r = $random(seed);
				issue_op(ex_pkg::EXEC_MULT, ex_pkg::ALU_ADD, ex_pkg::mult_func_e'(r[1:0]),
					ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2, '0, $random(seed), $random(seed),
					1'b0, 1'b0, 1'b1, "collision mult");
			end
			for (int i = 0; i < ex_pkg::NUM_STAGE; i++) begin
				r = $unsigned($random(seed)) % 10;
				issue_op(ex_pkg::EXEC_ALU, ex_pkg::alu_func_e'(r[3:0]), ex_pkg::MUL,
					ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2, '0, $random(seed), $random(seed),
					1'b0, 1'b0, 1'b1, "collision alu");
			end
		end
		idle(2);

		// tag 0 on every unit, nothing may write back
		for (int i = 0; i < 16; i++)
			issue_op(ex_pkg::exec_unit_e'(2'(i % 3)), ex_pkg::ALU_XOR, ex_pkg::MULH,
				ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_I_IMM, $random(seed), $random(seed),
				$random(seed), 1'b1, 1'b0, 1'b0, "tag zero");
		idle(1);

		while (outstanding != 0)
			@(posedge clock);
		idle(10); // late or duplicate completions show up here
		errors += u_ex_stage.u_ex_stage_props.fail_count;
		$display("checks %0d errors %0d issued %0d", checks, errors, issued);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/ex_pkg.sv
verilog/ex_operand_select.sv
verilog/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_mult_stage.sv
verilog/ex_multiplier.sv
verilog/ex_complete_queue.sv
verilog/ex_stage.sv
verification/ex_stage_props.sv
verification/ex_stage_tb.sv

//--- verilog/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	input  ex_pkg::xlen_t     op_a,
	input  ex_pkg::xlen_t     op_b,
	input  ex_pkg::alu_func_e func,
	output ex_pkg::xlen_t     result
);

	logic [4:0] shamt;

	assign shamt = op_b[4:0]; // RV32 shifts use five bits

	always_comb begin
		case (func)
			ex_pkg::ALU_ADD:  result = op_a + op_b;
			ex_pkg::ALU_SUB:  result = op_a - op_b;
			ex_pkg::ALU_AND:  result = op_a & op_b;
			ex_pkg::ALU_OR:   result = op_a | op_b;
			ex_pkg::ALU_XOR:  result = op_a ^ op_b;
			ex_pkg::ALU_SLT:  result = ex_pkg::xlen_t'($signed(op_a) < $signed(op_b));
			ex_pkg::ALU_SLTU: result = ex_pkg::xlen_t'(op_a < op_b);
			ex_pkg::ALU_SLL:  result = op_a << shamt;
			ex_pkg::ALU_SRL:  result = op_a >> shamt;
			ex_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt; // keeps sign bit
			default:          result = 32'hfacebeec;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
	input  logic          clock,
	input  logic          reset,
	input  logic          start,
	input  logic [2:0]    funct3,
	input  ex_pkg::xlen_t rs1,
	input  ex_pkg::xlen_t rs2,
	input  ex_pkg::xlen_t op_a,
	input  ex_pkg::xlen_t op_b,
	input  logic          cond_branch,
	input  logic          uncond_branch,
	output logic          branch_valid,
	output logic          take_branch,
	output ex_pkg::xlen_t branch_target
);

	logic cond;
	logic take_next;

	always_comb begin
		case (funct3)
			3'b000:  cond = (rs1 == rs2);                   // beq
			3'b001:  cond = (rs1 != rs2);                   // bne
			3'b100:  cond = ($signed(rs1) < $signed(rs2));  // blt
			3'b101:  cond = ($signed(rs1) >= $signed(rs2)); // bge
			3'b110:  cond = (rs1 < rs2);                    // bltu
			3'b111:  cond = (rs1 >= rs2);                   // bgeu
			default: cond = 1'b0;
		endcase
	end

	// jumps always go, conditional ones only on a true compare
	assign take_next = start && (uncond_branch || (cond_branch && cond));

	always_ff @(posedge clock) begin
		if (reset) begin
			branch_valid <= 1'b0;
			take_branch  <= 1'b0;
		end else begin
			branch_valid <= start;
			take_branch  <= take_next;
		end
	end

	always_ff @(posedge clock) begin
		branch_target <= op_a + op_b;
	end

endmodule

`default_nettype wire

//--- verilog/ex_complete_queue.sv
`timescale 1ns/1ps
`default_nettype none

module ex_complete_queue (
	input  logic          clock,
	input  logic          reset,
	input  logic          mult_done,
	input  ex_pkg::tag_t  mult_tag,
	input  ex_pkg::xlen_t mult_result,
	input  logic          local_valid,
	input  ex_pkg::tag_t  local_tag,
	input  ex_pkg::xlen_t local_result,
	output logic          complete_valid,
	output ex_pkg::tag_t  complete_tag,
	output ex_pkg::xlen_t complete_result,
	output logic          reg_wr_en
);

	ex_pkg::tag_t  tag_mem    [ex_pkg::COMPLETE_DEPTH];
	ex_pkg::xlen_t result_mem [ex_pkg::COMPLETE_DEPTH];

	logic [$clog2(ex_pkg::COMPLETE_DEPTH)-1:0]   head, tail;
	logic [$clog2(ex_pkg::COMPLETE_DEPTH)-1:0]   local_slot;
	logic [$clog2(ex_pkg::COMPLETE_DEPTH+1)-1:0] count;
	logic                                        push_mult, push_local, pop;
	logic [1:0]                                  num_push;

	// tag 0 results are dropped here
	assign push_mult  = mult_done && (mult_tag != '0);
	assign push_local = local_valid && (local_tag != '0);
	assign num_push   = {1'b0, push_mult} + {1'b0, push_local};
	assign pop        = (count != '0);

	// multiplier takes the first free slot when both arrive
	assign local_slot = push_mult ? tail + 1'b1 : tail;

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push_mult) begin
			tag_mem[tail]    <= mult_tag;
			result_mem[tail] <= mult_result;
		end
		if (push_local) begin
			tag_mem[local_slot]    <= local_tag;
			result_mem[local_slot] <= local_result;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pointers, occupancy and registered head
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head           <= '0;
			tail           <= '0;
			count          <= '0;
			complete_valid <= 1'b0;
		end else begin
			head           <= head + pop;      // wraps at the power-of-two depth
			tail           <= tail + num_push;
			count          <= count + num_push - pop;
			complete_valid <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			complete_tag    <= tag_mem[head];
			complete_result <= result_mem[head];
		end
	end

	assign reg_wr_en = complete_valid && (complete_tag != '0);

endmodule

`default_nettype wire

//--- verilog/ex_mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mult_stage (
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  ex_pkg::wide_t      mcand_in,
	input  ex_pkg::wide_t      mplier_in,
	input  ex_pkg::wide_t      product_in,
	input  ex_pkg::tag_t       tag_in,
	input  ex_pkg::mult_func_e func_in,
	output logic               done,
	output ex_pkg::wide_t      mcand_out,
	output ex_pkg::wide_t      mplier_out,
	output ex_pkg::wide_t      product_out,
	output ex_pkg::tag_t       tag_out,
	output ex_pkg::mult_func_e func_out
);

	ex_pkg::wide_t partial;

	// one slice of the multiplier against the whole multiplicand
	assign partial = mplier_in[ex_pkg::MULT_BITS-1:0] * mcand_in;

	always_ff @(posedge clock) begin
		product_out <= product_in + partial;
		mcand_out   <= mcand_in << ex_pkg::MULT_BITS;
		mplier_out  <= mplier_in >> ex_pkg::MULT_BITS; // next slice moves down
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done     <= 1'b0;
			tag_out  <= '0;
			func_out <= ex_pkg::MUL;
		end else begin
			done     <= start;
			tag_out  <= tag_in;
			func_out <= func_in;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ex_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module ex_multiplier (
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  ex_pkg::mult_func_e func,
	input  ex_pkg::xlen_t      mcand,
	input  ex_pkg::xlen_t      mplier,
	input  ex_pkg::tag_t       tag_in,
	output logic               done,
	output ex_pkg::xlen_t      product,
	output ex_pkg::tag_t       tag_out
);

	logic               mcand_signed, mplier_signed;
	ex_pkg::wide_t      mcand_chain   [ex_pkg::NUM_STAGE+1];
	ex_pkg::wide_t      mplier_chain  [ex_pkg::NUM_STAGE+1];
	ex_pkg::wide_t      product_chain [ex_pkg::NUM_STAGE+1];
	ex_pkg::tag_t       tag_chain     [ex_pkg::NUM_STAGE+1];
	ex_pkg::mult_func_e func_chain    [ex_pkg::NUM_STAGE+1];
	logic               done_chain    [ex_pkg::NUM_STAGE+1];

	// rs1 is signed except for mulhu, rs2 only for mul and mulh
	assign mcand_signed  = (func != ex_pkg::MULHU);
	assign mplier_signed = (func == ex_pkg::MUL) || (func == ex_pkg::MULH);

	assign mcand_chain[0]   = {{ex_pkg::XLEN{mcand_signed && mcand[ex_pkg::XLEN-1]}}, mcand};
	assign mplier_chain[0]  = {{ex_pkg::XLEN{mplier_signed && mplier[ex_pkg::XLEN-1]}}, mplier};
	assign product_chain[0] = '0;
	assign tag_chain[0]     = tag_in;
	assign func_chain[0]    = func;
	assign done_chain[0]    = start;

	for (genvar i = 0; i < ex_pkg::NUM_STAGE; i++) begin : g_stage
		ex_mult_stage u_mult_stage (
			.clock       (clock),
			.reset       (reset),
			.start       (done_chain[i]),
			.mcand_in    (mcand_chain[i]),
			.mplier_in   (mplier_chain[i]),
			.product_in  (product_chain[i]),
			.tag_in      (tag_chain[i]),
			.func_in     (func_chain[i]),
			.done        (done_chain[i+1]),
			.mcand_out   (mcand_chain[i+1]),
			.mplier_out  (mplier_chain[i+1]),
			.product_out (product_chain[i+1]),
			.tag_out     (tag_chain[i+1]),
			.func_out    (func_chain[i+1])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// result word chosen by the function that rode along with the operands
	////////////////////////////////////////////////////////////////////////////

	assign done    = done_chain[ex_pkg::NUM_STAGE];
	assign tag_out = tag_chain[ex_pkg::NUM_STAGE];
	assign product = (func_chain[ex_pkg::NUM_STAGE] == ex_pkg::MUL)
		? product_chain[ex_pkg::NUM_STAGE][ex_pkg::XLEN-1:0]
		: product_chain[ex_pkg::NUM_STAGE][2*ex_pkg::XLEN-1:ex_pkg::XLEN];

endmodule

`default_nettype wire

//--- verilog/ex_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module ex_operand_select (
	input  logic                 issue_valid,
	input  ex_pkg::exec_unit_e   issue_unit,
	input  ex_pkg::opa_sel_e     issue_opa_sel,
	input  ex_pkg::opb_sel_e     issue_opb_sel,
	input  ex_pkg::xlen_t        issue_inst,
	input  ex_pkg::xlen_t        issue_pc,
	input  ex_pkg::xlen_t        issue_npc,
	input  ex_pkg::xlen_t        issue_rs1_value,
	input  ex_pkg::xlen_t        issue_rs2_value,
	output ex_pkg::xlen_t        op_a,
	output ex_pkg::xlen_t        op_b,
	output logic                 alu_start,
	output logic                 branch_start,
	output logic                 mult_start
);

	ex_pkg::xlen_t i_imm, s_imm, b_imm, u_imm, j_imm;

	// RV32 immediate formats, all sign extended from bit 31
	assign i_imm = {{21{issue_inst[31]}}, issue_inst[30:20]};
	assign s_imm = {{21{issue_inst[31]}}, issue_inst[30:25], issue_inst[11:7]};
	assign b_imm = {{20{issue_inst[31]}}, issue_inst[7], issue_inst[30:25],
		issue_inst[11:8], 1'b0};
	assign u_imm = {issue_inst[31:12], 12'b0};
	assign j_imm = {{12{issue_inst[31]}}, issue_inst[19:12], issue_inst[20],
		issue_inst[30:21], 1'b0};

	always_comb begin
		case (issue_opa_sel)
			ex_pkg::OPA_IS_RS1:  op_a = issue_rs1_value;
			ex_pkg::OPA_IS_NPC:  op_a = issue_npc;
			ex_pkg::OPA_IS_PC:   op_a = issue_pc;
			ex_pkg::OPA_IS_ZERO: op_a = '0;
			default:             op_a = 32'hdeadfbac; // bad select marker
		endcase
	end

	always_comb begin
		case (issue_opb_sel)
			ex_pkg::OPB_IS_RS2:   op_b = issue_rs2_value;
			ex_pkg::OPB_IS_I_IMM: op_b = i_imm;
			ex_pkg::OPB_IS_S_IMM: op_b = s_imm;
			ex_pkg::OPB_IS_B_IMM: op_b = b_imm;
			ex_pkg::OPB_IS_U_IMM: op_b = u_imm;
			ex_pkg::OPB_IS_J_IMM: op_b = j_imm;
			default:              op_b = 32'hfacefeed;
		endcase
	end

	// one strobe per valid issue
	assign alu_start    = issue_valid && (issue_unit == ex_pkg::EXEC_ALU);
	assign branch_start = issue_valid && (issue_unit == ex_pkg::EXEC_BRANCH);
	assign mult_start   = issue_valid && (issue_unit == ex_pkg::EXEC_MULT);

endmodule

`default_nettype wire

//--- verilog/ex_pkg.sv
`default_nettype none

package ex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int XLEN           = 32;
	localparam int TAG_BITS       = 6;                      // physical register tag
	localparam int NUM_STAGE      = 4;                      // multiplier pipeline depth
	localparam int MULT_BITS      = 2 * XLEN / NUM_STAGE;   // multiplier bits per stage
	localparam int COMPLETE_DEPTH = 8;                      // power of two, pointers wrap

	typedef logic [XLEN-1:0]     xlen_t;
	typedef logic [2*XLEN-1:0]   wide_t;   // full product
	typedef logic [TAG_BITS-1:0] tag_t;    // tag 0 never writes back

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		EXEC_ALU    = 2'd0,
		EXEC_MULT   = 2'd1,
		EXEC_BRANCH = 2'd2
	} exec_unit_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_func_e;

	typedef enum logic [1:0] {
		MUL    = 2'd0,   // low word
		MULH   = 2'd1,   // signed x signed, high word
		MULHSU = 2'd2,   // signed rs1 x unsigned rs2
		MULHU  = 2'd3
	} mult_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'd0,
		OPA_IS_NPC  = 2'd1,
		OPA_IS_PC   = 2'd2,
		OPA_IS_ZERO = 2'd3
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'd0,
		OPB_IS_I_IMM = 3'd1,
		OPB_IS_S_IMM = 3'd2,
		OPB_IS_B_IMM = 3'd3,
		OPB_IS_U_IMM = 3'd4,
		OPB_IS_J_IMM = 3'd5
	} opb_sel_e;

endpackage

`default_nettype wire

//--- verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic               clock,
	input  logic               reset,
	// issue
	input  logic               issue_valid,
	input  ex_pkg::exec_unit_e issue_unit,
	input  ex_pkg::alu_func_e  issue_alu_func,
	input  ex_pkg::mult_func_e issue_mult_func,
	input  ex_pkg::opa_sel_e   issue_opa_sel,
	input  ex_pkg::opb_sel_e   issue_opb_sel,
	input  ex_pkg::xlen_t      issue_inst,
	input  ex_pkg::xlen_t      issue_pc,
	input  ex_pkg::xlen_t      issue_npc,
	input  ex_pkg::xlen_t      issue_rs1_value,
	input  ex_pkg::xlen_t      issue_rs2_value,
	input  ex_pkg::tag_t       issue_dest_tag,
	input  logic               issue_cond_branch,
	input  logic               issue_uncond_branch,
	// writeback
	output logic               complete_valid,
	output ex_pkg::tag_t       complete_tag,
	output ex_pkg::xlen_t      complete_result,
	output logic               reg_wr_en,
	// branch resolution, one cycle after issue
	output logic               branch_valid,
	output logic               take_branch,
	output ex_pkg::xlen_t      branch_target
);

	ex_pkg::xlen_t op_a, op_b;
	ex_pkg::xlen_t alu_result;
	ex_pkg::xlen_t local_result;
	ex_pkg::xlen_t mult_result;
	ex_pkg::tag_t  mult_tag;
	logic          alu_start, branch_start, mult_start;
	logic          local_valid;
	logic          mult_done;

	ex_operand_select u_operand_select (
		.issue_valid     (issue_valid),
		.issue_unit      (issue_unit),
		.issue_opa_sel   (issue_opa_sel),
		.issue_opb_sel   (issue_opb_sel),
		.issue_inst      (issue_inst),
		.issue_pc        (issue_pc),
		.issue_npc       (issue_npc),
		.issue_rs1_value (issue_rs1_value),
		.issue_rs2_value (issue_rs2_value),
		.op_a            (op_a),
		.op_b            (op_b),
		.alu_start       (alu_start),
		.branch_start    (branch_start),
		.mult_start      (mult_start)
	);

	ex_alu u_alu (
		.op_a   (op_a),
		.op_b   (op_b),
		.func   (issue_alu_func),
		.result (alu_result)
	);

	ex_branch_unit u_branch_unit (
		.clock         (clock),
		.reset         (reset),
		.start         (branch_start),
		.funct3        (issue_inst[14:12]),
		.rs1           (issue_rs1_value),
		.rs2           (issue_rs2_value),
		.op_a          (op_a),
		.op_b          (op_b),
		.cond_branch   (issue_cond_branch),
		.uncond_branch (issue_uncond_branch),
		.branch_valid  (branch_valid),
		.take_branch   (take_branch),
		.branch_target (branch_target)
	);

	ex_multiplier u_multiplier (
		.clock   (clock),
		.reset   (reset),
		.start   (mult_start),
		.func    (issue_mult_func),
		.mcand   (issue_rs1_value),
		.mplier  (issue_rs2_value),
		.tag_in  (issue_dest_tag),
		.done    (mult_done),
		.product (mult_result),
		.tag_out (mult_tag)
	);

	// alu and branch share the same-cycle queue input, branch links npc
	assign local_valid  = alu_start || branch_start;
	assign local_result = branch_start ? issue_npc : alu_result;

	ex_complete_queue u_complete_queue (
		.clock           (clock),
		.reset           (reset),
		.mult_done       (mult_done),
		.mult_tag        (mult_tag),
		.mult_result     (mult_result),
		.local_valid     (local_valid),
		.local_tag       (issue_dest_tag),
		.local_result    (local_result),
		.complete_valid  (complete_valid),
		.complete_tag    (complete_tag),
		.complete_result (complete_result),
		.reg_wr_en       (reg_wr_en)
	);

endmodule

`default_nettype wire
